// File: logic/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath word
`define WORD_W 16

// register file geometry
`define REG_COUNT 4
`define REG_ADDR_W 2

// i-type immediate field
`define IMM_W 8

`endif

// File: logic/isa_pkg.sv
`include "cpu_defines.svh"

package isa_pkg;

   // top nibble of the instruction word
   typedef enum logic [3:0] {
      OP_ADI   = 4'd4,
      OP_ORI   = 4'd5,
      OP_LHI   = 4'd6,
      OP_RTYPE = 4'd15
   } opcode_e;

   // low six bits, r-type only
   typedef enum logic [5:0] {
      FN_ADD = 6'd0,
      FN_SUB = 6'd1,
      FN_AND = 6'd2,
      FN_ORR = 6'd3,
      FN_NOT = 6'd4,
      FN_TCP = 6'd5,
      FN_SHL = 6'd6,
      FN_SHR = 6'd7,
      FN_WWD = 6'd28,
      FN_HLT = 6'd29
   } func_e;

   typedef struct packed {
      opcode_e                opcode;
      logic [`REG_ADDR_W-1:0] rs;
      logic [`REG_ADDR_W-1:0] rt;
      logic [`REG_ADDR_W-1:0] rd;
      func_e                  func;
   } r_form_t;

   // same word, low byte read as immediate
   typedef struct packed {
      opcode_e                opcode;
      logic [`REG_ADDR_W-1:0] rs;
      logic [`REG_ADDR_W-1:0] rt;
      logic [`IMM_W-1:0]      imm;
   } i_form_t;

   typedef union packed {
      r_form_t r_form;
      i_form_t i_form;
   } inst_word_u;

endpackage

// File: logic/pipe_pkg.sv
package pipe_pkg;

   // what execute does with its two operands
   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_AND    = 4'd2,
      ALU_OR     = 4'd3,
      ALU_NOT    = 4'd4,
      ALU_TCP    = 4'd5,
      ALU_SHL    = 4'd6,
      ALU_SHR    = 4'd7,
      ALU_PASS_B = 4'd8
   } alu_op_e;

   // where an execute operand comes from
   // mem wins over wb, wb over the file
   typedef enum logic [1:0] {
      FWD_RF  = 2'd0,
      FWD_MEM = 2'd1,
      FWD_WB  = 2'd2
   } fwd_src_e;

endpackage

// File: logic/inst_decoder.sv
`include "cpu_defines.svh"

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
   input  logic                   clk,
   input  logic                   reset_n,
   input  inst_word_u             i_inst,
   input  logic                   i_inst_valid,
   input  logic                   i_halted,
   output logic                   o_valid,
   output logic [`REG_ADDR_W-1:0] o_rs,
   output logic [`REG_ADDR_W-1:0] o_rt,
   output logic [`REG_ADDR_W-1:0] o_dst,
   output logic [`WORD_W-1:0]     o_imm,
   output logic                   o_use_imm,
   output alu_op_e                o_alu_op,
   output logic                   o_reg_write,
   output logic                   o_output_write,
   output logic                   o_halt
);

   inst_word_u inst_q;
   logic       halt_seen;
   logic       accept;
   logic       dec_we;
   logic       dec_out;
   logic       dec_halt;

   // hlt in ID or already passed blocks everything behind it
   assign accept = i_inst_valid && !i_halted && !halt_seen && !o_halt;

   ////////////////////
   // instruction latch
   ////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_valid   <= 1'b0;
         halt_seen <= 1'b0;
      end else begin
         o_valid   <= accept;
         halt_seen <= halt_seen | o_halt;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         inst_q <= i_inst;
      end
   end

   ////////////////////
   // decode
   ////////////////////

   assign o_rs = inst_q.r_form.rs;
   assign o_rt = inst_q.r_form.rt;

   always_comb begin
      // defaults describe a no-op
      o_alu_op  = ALU_PASS_B;
      o_use_imm = 1'b0;
      o_dst     = inst_q.r_form.rd;
      o_imm     = {{(`WORD_W-`IMM_W){inst_q.i_form.imm[`IMM_W-1]}}, inst_q.i_form.imm};
      dec_we    = 1'b0;
      dec_out   = 1'b0;
      dec_halt  = 1'b0;
      case (inst_q.r_form.opcode)
         OP_ADI: begin
            // sign-extended immediate, default above
            o_alu_op  = ALU_ADD;
            o_use_imm = 1'b1;
            o_dst     = inst_q.i_form.rt;
            dec_we    = 1'b1;
         end
         OP_ORI: begin
            o_alu_op  = ALU_OR;
            o_use_imm = 1'b1;
            o_imm     = {{(`WORD_W-`IMM_W){1'b0}}, inst_q.i_form.imm};
            o_dst     = inst_q.i_form.rt;
            dec_we    = 1'b1;
         end
         OP_LHI: begin
            // upper byte, lower byte zero
            o_alu_op  = ALU_PASS_B;
            o_use_imm = 1'b1;
            o_imm     = {inst_q.i_form.imm, {(`WORD_W-`IMM_W){1'b0}}};
            o_dst     = inst_q.i_form.rt;
            dec_we    = 1'b1;
         end
         OP_RTYPE: begin
            dec_we = 1'b1;
            case (inst_q.r_form.func)
               FN_ADD: o_alu_op = ALU_ADD;
               FN_SUB: o_alu_op = ALU_SUB;
               FN_AND: o_alu_op = ALU_AND;
               FN_ORR: o_alu_op = ALU_OR;
               FN_NOT: o_alu_op = ALU_NOT;
               FN_TCP: o_alu_op = ALU_TCP;
               FN_SHL: o_alu_op = ALU_SHL;
               FN_SHR: o_alu_op = ALU_SHR;
               FN_WWD: begin
                  dec_we  = 1'b0;
                  dec_out = 1'b1;
               end
               FN_HLT: begin
                  dec_we   = 1'b0;
                  dec_halt = 1'b1;
               end
               // unknown func, retires but writes nothing
               default: dec_we = 1'b0;
            endcase
         end
         default: ;
      endcase
   end

   // bubbles carry no side effects
   assign o_reg_write    = o_valid && dec_we;
   assign o_output_write = o_valid && dec_out;
   assign o_halt         = o_valid && dec_halt;

   // one instruction never both writes a register and the port
   a_one_sink: assert property (@(posedge clk) disable iff (!reset_n)
      !(o_reg_write && o_output_write));

endmodule

// File: logic/reg_file.sv
`include "cpu_defines.svh"

module reg_file (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic [`REG_ADDR_W-1:0] i_raddr1,
   input  logic [`REG_ADDR_W-1:0] i_raddr2,
   input  logic                   i_we,
   input  logic [`REG_ADDR_W-1:0] i_waddr,
   input  logic [`WORD_W-1:0]     i_wdata,
   output logic [`WORD_W-1:0]     o_rdata1,
   output logic [`WORD_W-1:0]     o_rdata2
);

   logic [`WORD_W-1:0] regs [`REG_COUNT];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_waddr] <= i_wdata;
      end
   end

   // write-through so ID sees what WB writes this cycle
   assign o_rdata1 = (i_we && i_waddr == i_raddr1) ? i_wdata : regs[i_raddr1];
   assign o_rdata2 = (i_we && i_waddr == i_raddr2) ? i_wdata : regs[i_raddr2];

   // data arriving from writeback must be resolved
   a_wdata_known: assert property (@(posedge clk) disable iff (!reset_n)
      i_we |-> !$isunknown(i_wdata));

endmodule

// File: logic/alu.sv
`include "cpu_defines.svh"

module alu import pipe_pkg::*; (
   input  alu_op_e            i_op,
   input  logic [`WORD_W-1:0] i_a,
   input  logic [`WORD_W-1:0] i_b,
   output logic [`WORD_W-1:0] o_result
);

   always_comb begin
      case (i_op)
         ALU_ADD: o_result = i_a + i_b;
         ALU_SUB: o_result = i_a - i_b;
         ALU_AND: o_result = i_a & i_b;
         ALU_OR:  o_result = i_a | i_b;
         // unary ops work on operand a
         ALU_NOT: o_result = ~i_a;
         ALU_TCP: o_result = ~i_a + 1'b1;
         // single-bit shifts
         ALU_SHL: o_result = {i_a[`WORD_W-2:0], 1'b0};
         // arithmetic, sign bit kept
         ALU_SHR: o_result = {i_a[`WORD_W-1], i_a[`WORD_W-1:1]};
         // lhi goes straight through
         ALU_PASS_B: o_result = i_b;
         default: o_result = '0;
      endcase
   end

endmodule

// File: logic/exec_stage.sv
`include "cpu_defines.svh"

module exec_stage import pipe_pkg::*; (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   i_valid,
   input  logic [`REG_ADDR_W-1:0] i_rs,
   input  logic [`REG_ADDR_W-1:0] i_rt,
   input  logic [`REG_ADDR_W-1:0] i_dst,
   input  logic [`WORD_W-1:0]     i_imm,
   input  logic                   i_use_imm,
   input  alu_op_e                i_alu_op,
   input  logic                   i_reg_write,
   input  logic                   i_output_write,
   input  logic                   i_halt,
   input  logic [`WORD_W-1:0]     i_rdata1,
   input  logic [`WORD_W-1:0]     i_rdata2,
   input  logic [`REG_ADDR_W-1:0] i_mem_dst,
   input  logic                   i_mem_we,
   input  logic [`WORD_W-1:0]     i_mem_result,
   input  logic [`REG_ADDR_W-1:0] i_wb_dst,
   input  logic                   i_wb_we,
   input  logic [`WORD_W-1:0]     i_wb_result,
   output logic                   o_valid,
   output logic [`WORD_W-1:0]     o_result,
   output logic [`REG_ADDR_W-1:0] o_dst,
   output logic                   o_reg_write,
   output logic                   o_halt,
   output logic [`WORD_W-1:0]     o_output_port,
   output logic                   o_output_valid
);

   logic [`REG_ADDR_W-1:0] ex_rs;
   logic [`REG_ADDR_W-1:0] ex_rt;
   logic [`WORD_W-1:0]     ex_imm;
   logic                   ex_use_imm;
   alu_op_e                ex_alu_op;
   logic [`WORD_W-1:0]     ex_a;
   logic [`WORD_W-1:0]     ex_b;
   logic                   ex_output_write;
   fwd_src_e               src_a;
   fwd_src_e               src_b;
   logic [`WORD_W-1:0]     a_fwd;
   logic [`WORD_W-1:0]     b_fwd;
   logic [`WORD_W-1:0]     alu_b;

   // closest writer wins
   function automatic fwd_src_e fwd_pick(
      input logic [`REG_ADDR_W-1:0] addr,
      input logic                   mem_we,
      input logic [`REG_ADDR_W-1:0] mem_dst,
      input logic                   wb_we,
      input logic [`REG_ADDR_W-1:0] wb_dst
   );
      if (mem_we && mem_dst == addr) begin
         return FWD_MEM;
      end else if (wb_we && wb_dst == addr) begin
         return FWD_WB;
      end
      return FWD_RF;
   endfunction

   ////////////////////
   // ID/EX latch
   ////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_valid         <= 1'b0;
         o_reg_write     <= 1'b0;
         ex_output_write <= 1'b0;
         o_halt          <= 1'b0;
      end else begin
         o_valid         <= i_valid;
         o_reg_write     <= i_reg_write;
         ex_output_write <= i_output_write;
         o_halt          <= i_halt;
      end
   end

   always_ff @(posedge clk) begin
      ex_rs      <= i_rs;
      ex_rt      <= i_rt;
      o_dst      <= i_dst;
      ex_imm     <= i_imm;
      ex_use_imm <= i_use_imm;
      ex_alu_op  <= i_alu_op;
      ex_a       <= i_rdata1;
      ex_b       <= i_rdata2;
   end

   ////////////////////
   // operand select
   ////////////////////

   assign src_a = fwd_pick(ex_rs, i_mem_we, i_mem_dst, i_wb_we, i_wb_dst);
   assign src_b = fwd_pick(ex_rt, i_mem_we, i_mem_dst, i_wb_we, i_wb_dst);

   always_comb begin
      case (src_a)
         FWD_MEM: a_fwd = i_mem_result;
         FWD_WB:  a_fwd = i_wb_result;
         default: a_fwd = ex_a;
      endcase
      case (src_b)
         FWD_MEM: b_fwd = i_mem_result;
         FWD_WB:  b_fwd = i_wb_result;
         default: b_fwd = ex_b;
      endcase
   end

   // i-type replaces rt with the formed immediate
   assign alu_b = ex_use_imm ? ex_imm : b_fwd;

   alu u_alu (
      .i_op     (ex_alu_op),
      .i_a      (a_fwd),
      .i_b      (alu_b),
      .o_result (o_result)
   );

   // wwd, forwarded rs onto the port
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_output_valid <= 1'b0;
      end else begin
         o_output_valid <= ex_output_write;
      end
   end

   always_ff @(posedge clk) begin
      if (ex_output_write) begin
         o_output_port <= a_fwd;
      end
   end

endmodule

// File: logic/writeback_stage.sv
`include "cpu_defines.svh"

module writeback_stage (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   i_valid,
   input  logic [`WORD_W-1:0]     i_result,
   input  logic [`REG_ADDR_W-1:0] i_dst,
   input  logic                   i_reg_write,
   input  logic                   i_halt,
   output logic [`REG_ADDR_W-1:0] o_mem_dst,
   output logic                   o_mem_we,
   output logic [`WORD_W-1:0]     o_mem_result,
   output logic [`REG_ADDR_W-1:0] o_wb_dst,
   output logic                   o_wb_we,
   output logic [`WORD_W-1:0]     o_wb_result,
   output logic [`WORD_W-1:0]     o_num_inst,
   output logic                   o_halted
);

   logic mem_valid;
   logic mem_halt;

   ////////////////////
   // MEM and WB latches
   ////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         mem_valid <= 1'b0;
         o_mem_we  <= 1'b0;
         mem_halt  <= 1'b0;
         o_wb_we   <= 1'b0;
      end else begin
         mem_valid <= i_valid;
         o_mem_we  <= i_reg_write;
         mem_halt  <= i_halt;
         o_wb_we   <= o_mem_we;
      end
   end

   // no memory access, result passes through MEM unchanged
   always_ff @(posedge clk) begin
      o_mem_dst    <= i_dst;
      o_mem_result <= i_result;
      o_wb_dst     <= o_mem_dst;
      o_wb_result  <= o_mem_result;
   end

   // retire on entry to WB, same edge as the halt flag
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_num_inst <= '0;
         o_halted   <= 1'b0;
      end else begin
         if (mem_valid) begin
            o_num_inst <= o_num_inst + 1'b1;
         end
         // sticky until reset
         o_halted <= o_halted | (mem_valid && mem_halt);
      end
   end

   // nothing retires behind a hlt
   a_frozen_count: assert property (@(posedge clk) disable iff (!reset_n)
      o_halted |=> $stable(o_num_inst));

endmodule

// File: logic/cpu_top.sv
`include "cpu_defines.svh"

module cpu_top import isa_pkg::*, pipe_pkg::*; (
   input  logic               clk,
   input  logic               reset_n,
   input  inst_word_u         i_inst,
   input  logic               i_inst_valid,
   output logic [`WORD_W-1:0] o_output_port,
   output logic               o_output_valid,
   output logic [`WORD_W-1:0] o_num_inst,
   output logic               o_halted
);

   // ID outputs
   logic                   id_valid;
   logic [`REG_ADDR_W-1:0] id_rs;
   logic [`REG_ADDR_W-1:0] id_rt;
   logic [`REG_ADDR_W-1:0] id_dst;
   logic [`WORD_W-1:0]     id_imm;
   logic                   id_use_imm;
   alu_op_e                id_alu_op;
   logic                   id_reg_write;
   logic                   id_output_write;
   logic                   id_halt;
   logic [`WORD_W-1:0]     rf_rdata1;
   logic [`WORD_W-1:0]     rf_rdata2;

   // EX outputs
   logic                   ex_valid;
   logic [`WORD_W-1:0]     ex_result;
   logic [`REG_ADDR_W-1:0] ex_dst;
   logic                   ex_reg_write;
   logic                   ex_halt;

   // MEM and WB, also the forwarding taps
   logic [`REG_ADDR_W-1:0] mem_dst;
   logic                   mem_we;
   logic [`WORD_W-1:0]     mem_result;
   logic [`REG_ADDR_W-1:0] wb_dst;
   logic                   wb_we;
   logic [`WORD_W-1:0]     wb_result;

   inst_decoder u_inst_decoder (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_inst         (i_inst),
      .i_inst_valid   (i_inst_valid),
      .i_halted       (o_halted),
      .o_valid        (id_valid),
      .o_rs           (id_rs),
      .o_rt           (id_rt),
      .o_dst          (id_dst),
      .o_imm          (id_imm),
      .o_use_imm      (id_use_imm),
      .o_alu_op       (id_alu_op),
      .o_reg_write    (id_reg_write),
      .o_output_write (id_output_write),
      .o_halt         (id_halt)
   );

   reg_file u_reg_file (
      .clk      (clk),
      .reset_n  (reset_n),
      .i_raddr1 (id_rs),
      .i_raddr2 (id_rt),
      .i_we     (wb_we),
      .i_waddr  (wb_dst),
      .i_wdata  (wb_result),
      .o_rdata1 (rf_rdata1),
      .o_rdata2 (rf_rdata2)
   );

   exec_stage u_exec_stage (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_valid        (id_valid),
      .i_rs           (id_rs),
      .i_rt           (id_rt),
      .i_dst          (id_dst),
      .i_imm          (id_imm),
      .i_use_imm      (id_use_imm),
      .i_alu_op       (id_alu_op),
      .i_reg_write    (id_reg_write),
      .i_output_write (id_output_write),
      .i_halt         (id_halt),
      .i_rdata1       (rf_rdata1),
      .i_rdata2       (rf_rdata2),
      .i_mem_dst      (mem_dst),
      .i_mem_we       (mem_we),
      .i_mem_result   (mem_result),
      .i_wb_dst       (wb_dst),
      .i_wb_we        (wb_we),
      .i_wb_result    (wb_result),
      .o_valid        (ex_valid),
      .o_result       (ex_result),
      .o_dst          (ex_dst),
      .o_reg_write    (ex_reg_write),
      .o_halt         (ex_halt),
      .o_output_port  (o_output_port),
      .o_output_valid (o_output_valid)
   );

   writeback_stage u_writeback_stage (
      .clk          (clk),
      .reset_n      (reset_n),
      .i_valid      (ex_valid),
      .i_result     (ex_result),
      .i_dst        (ex_dst),
      .i_reg_write  (ex_reg_write),
      .i_halt       (ex_halt),
      .o_mem_dst    (mem_dst),
      .o_mem_we     (mem_we),
      .o_mem_result (mem_result),
      .o_wb_dst     (wb_dst),
      .o_wb_we      (wb_we),
      .o_wb_result  (wb_result),
      .o_num_inst   (o_num_inst),
      .o_halted     (o_halted)
   );

endmodule

// File: test/tb_cpu_top.sv
`include "cpu_defines.svh"

module tb_cpu_top import isa_pkg::*;;

   localparam int DRAIN_LIMIT = 20;
   localparam int HALT_LIMIT  = 10;

   logic               clk;
   logic               reset_n;
   inst_word_u         i_inst;
   logic               i_inst_valid;
   logic [`WORD_W-1:0] o_output_port;
   logic               o_output_valid;
   logic [`WORD_W-1:0] o_num_inst;
   logic               o_halted;

   // reference model state
   logic [`WORD_W-1:0] ref_regs [`REG_COUNT];
   logic               model_halted;
   int                 edge_no;
   int                 halt_due;
   logic [`WORD_W-1:0] out_val_q [$];
   int                 out_due_q [$];
   int                 ret_due_q [$];

   // what the outputs should show after each edge
   logic               check_en = 1'b0;
   logic               exp_out_valid;
   logic [`WORD_W-1:0] exp_out_port;
   logic [`WORD_W-1:0] exp_num_inst;
   logic               exp_halted;

   logic [31:0]        rng_state = 32'h0733cc9a;

   cpu_top u_dut (
      .clk            (clk),
      .reset_n        (reset_n),
      .i_inst         (i_inst),
      .i_inst_valid   (i_inst_valid),
      .o_output_port  (o_output_port),
      .o_output_valid (o_output_valid),
      .o_num_inst     (o_num_inst),
      .o_halted       (o_halted)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////
   // helpers
   ////////////////////

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic flag_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      stop_on_error($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   function automatic inst_word_u rtype_word(input func_e fn, input logic [1:0] rs,
                                             input logic [1:0] rt, input logic [1:0] rd);
      inst_word_u w;
      w.r_form.opcode = OP_RTYPE;
      w.r_form.rs     = rs;
      w.r_form.rt     = rt;
      w.r_form.rd     = rd;
      w.r_form.func   = fn;
      return w;
   endfunction

   function automatic inst_word_u itype_word(input opcode_e op, input logic [1:0] rs,
                                             input logic [1:0] rt, input logic [7:0] imm);
      inst_word_u w;
      w.i_form.opcode = op;
      w.i_form.rs     = rs;
      w.i_form.rt     = rt;
      w.i_form.imm    = imm;
      return w;
   endfunction

   // mix of kept ops, wwd and unknown words, never hlt
   function automatic inst_word_u random_inst(input logic [31:0] r);
      inst_word_u w;
      case (r[3:0])
         4'd8, 4'd9, 4'd15: w = rtype_word(FN_WWD, r[5:4], r[7:6], r[9:8]);
         4'd10: w = itype_word(OP_ADI, r[5:4], r[7:6], r[17:10]);
         4'd11: w = itype_word(OP_ORI, r[5:4], r[7:6], r[17:10]);
         4'd12: w = itype_word(OP_LHI, r[5:4], r[7:6], r[17:10]);
         4'd13: begin
            // opcode outside the kept set
            w = r[31:16];
            if (w[15:12] inside {4'd4, 4'd5, 4'd6, 4'd15}) begin
               w[15:12] = 4'd1;
            end
         end
         // r-type with func 32..47, nothing decodes there
         4'd14: w = {4'hf, r[5:4], r[7:6], r[9:8], 6'd32 + 6'(r[13:10])};
         default: w = rtype_word(func_e'({3'b000, r[2:0]}), r[5:4], r[7:6], r[9:8]);
      endcase
      return w;
   endfunction

   task automatic issue_inst(input inst_word_u w);
      @(posedge clk);
      i_inst       <= w;
      i_inst_valid <= 1'b1;
   endtask

   // junk on i_inst while valid is low
   task automatic idle_cycles(input int n);
      logic [31:0] r;
      repeat (n) begin
         @(posedge clk);
         r = next_random();
         i_inst       <= r[15:0];
         i_inst_valid <= 1'b0;
      end
   endtask

   task automatic wait_drained(input int limit);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
         if (n > limit) begin
            stop_on_error("accepted instructions did not retire within the timeout");
         end
      end while (ret_due_q.size() != 0 || out_due_q.size() != 0);
   endtask

   task automatic wait_halted(input int limit);
      int n;
      n = 0;
      while (!o_halted) begin
         @(posedge clk);
         n++;
         if (n > limit) begin
            stop_on_error("o_halted did not rise after the HLT");
         end
      end
   endtask

   ////////////////////
   // reference model
   ////////////////////

   // sequential semantics, forwarding makes the pipe match
   task automatic execute_model(input inst_word_u w);
      logic [`WORD_W-1:0]        a;
      logic [`WORD_W-1:0]        b;
      logic signed [`WORD_W-1:0] simm;
      a    = ref_regs[w.r_form.rs];
      b    = ref_regs[w.r_form.rt];
      simm = $signed(w.i_form.imm);
      case (w.r_form.opcode)
         OP_ADI: ref_regs[w.i_form.rt] = a + simm;
         OP_ORI: ref_regs[w.i_form.rt] = a | {8'h00, w.i_form.imm};
         OP_LHI: ref_regs[w.i_form.rt] = {w.i_form.imm, 8'h00};
         OP_RTYPE: begin
            case (w.r_form.func)
               FN_ADD: ref_regs[w.r_form.rd] = a + b;
               FN_SUB: ref_regs[w.r_form.rd] = a - b;
               FN_AND: ref_regs[w.r_form.rd] = a & b;
               FN_ORR: ref_regs[w.r_form.rd] = a | b;
               FN_NOT: ref_regs[w.r_form.rd] = ~a;
               FN_TCP: ref_regs[w.r_form.rd] = -a;
               FN_SHL: ref_regs[w.r_form.rd] = a << 1;
               // sign bit kept
               FN_SHR: ref_regs[w.r_form.rd] = $signed(a) >>> 1;
               FN_WWD: begin
                  out_val_q.push_back(a);
                  out_due_q.push_back(edge_no + 2);
               end
               FN_HLT: begin
                  model_halted = 1'b1;
                  halt_due     = edge_no + 3;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   endtask

   always @(posedge clk) begin
      if (!reset_n) begin
         check_en     <= 1'b1;
         edge_no      = 0;
         halt_due     = -1;
         model_halted = 1'b0;
         out_val_q.delete();
         out_due_q.delete();
         ret_due_q.delete();
         for (int i = 0; i < `REG_COUNT; i++) begin
            ref_regs[i] = '0;
         end
         exp_out_valid <= 1'b0;
         exp_num_inst  <= '0;
         exp_halted    <= 1'b0;
      end else begin
         edge_no = edge_no + 1;
         // nothing is taken once hlt was accepted
         if (i_inst_valid && !model_halted) begin
            ret_due_q.push_back(edge_no + 3);
            execute_model(i_inst);
         end
         if (ret_due_q.size() != 0 && ret_due_q[0] == edge_no) begin
            void'(ret_due_q.pop_front());
            exp_num_inst <= exp_num_inst + 1'b1;
         end
         if (edge_no == halt_due) begin
            exp_halted <= 1'b1;
         end
         if (out_due_q.size() != 0 && out_due_q[0] == edge_no) begin
            void'(out_due_q.pop_front());
            exp_out_valid <= 1'b1;
            exp_out_port  <= out_val_q.pop_front();
         end else begin
            exp_out_valid <= 1'b0;
         end
      end
   end

   ////////////////////
   // checks
   ////////////////////

   // pulse timing, also no pulse without a wwd
   a_out_valid: assert property (@(posedge clk)
      check_en |-> o_output_valid == exp_out_valid)
      else flag_mismatch("o_output_valid", $sampled(o_output_valid), $sampled(exp_out_valid));

   a_out_port: assert property (@(posedge clk)
      check_en && exp_out_valid |-> o_output_port == exp_out_port)
      else flag_mismatch("o_output_port", $sampled(o_output_port), $sampled(exp_out_port));

   a_num_inst: assert property (@(posedge clk)
      check_en |-> o_num_inst == exp_num_inst)
      else flag_mismatch("o_num_inst", $sampled(o_num_inst), $sampled(exp_num_inst));

   a_halted: assert property (@(posedge clk)
      check_en |-> o_halted == exp_halted)
      else flag_mismatch("o_halted", $sampled(o_halted), $sampled(exp_halted));

   ////////////////////
   // stimulus
   ////////////////////

   initial begin
      logic [31:0] r;
      reset_n      <= 1'b0;
      i_inst_valid <= 1'b0;
      i_inst       <= '0;
      repeat (10) @(posedge clk);
      reset_n <= 1'b1;
      idle_cycles(2);

      // every register reads zero after reset
      for (int i = 0; i < `REG_COUNT; i++) begin
         issue_inst(rtype_word(FN_WWD, 2'(i), 2'd0, 2'd0));
      end
      idle_cycles(1);
      wait_drained(DRAIN_LIMIT);

      // load all four, ori right behind lhi hits mem forwarding
      for (int i = 0; i < `REG_COUNT; i++) begin
         r = next_random();
         issue_inst(itype_word(OP_LHI, 2'd0, 2'(i), r[7:0]));
         issue_inst(itype_word(OP_ORI, 2'(i), 2'(i), r[15:8]));
      end
      // dependent r-type chain, distances one to three
      repeat (40) begin
         r = next_random();
         issue_inst(rtype_word(func_e'({3'b000, r[2:0]}), r[4:3], r[6:5], r[8:7]));
         if (r[9]) begin
            issue_inst(rtype_word(FN_WWD, r[8:7], 2'd0, 2'd0));
         end
      end
      idle_cycles(1);
      wait_drained(DRAIN_LIMIT);

      // immediate forms read back through the port
      repeat (30) begin
         r = next_random();
         case (r[1:0])
            2'd0: issue_inst(itype_word(OP_ORI, r[3:2], r[5:4], r[13:6]));
            2'd1: issue_inst(itype_word(OP_LHI, r[3:2], r[5:4], r[13:6]));
            default: issue_inst(itype_word(OP_ADI, r[3:2], r[5:4], r[13:6]));
         endcase
         idle_cycles(int'(r[15:14]) % 3);
         issue_inst(rtype_word(FN_WWD, r[5:4], 2'd0, 2'd0));
      end
      idle_cycles(1);
      wait_drained(DRAIN_LIMIT);

      // random mix with random bubbles
      repeat (200) begin
         r = next_random();
         issue_inst(random_inst(r));
         if (r[19:18] == 2'd0) begin
            idle_cycles(1 + int'(r[21:20]));
         end
      end
      idle_cycles(1);
      wait_drained(DRAIN_LIMIT);

      // hlt, then traffic that must be ignored
      issue_inst(rtype_word(FN_HLT, 2'd0, 2'd0, 2'd0));
      issue_inst(rtype_word(FN_WWD, 2'd1, 2'd0, 2'd0));
      repeat (5) begin
         issue_inst(random_inst(next_random()));
      end
      idle_cycles(1);
      wait_halted(HALT_LIMIT);
      repeat (8) begin
         issue_inst(rtype_word(FN_WWD, 2'd2, 2'd0, 2'd0));
         issue_inst(random_inst(next_random()));
      end
      idle_cycles(1);
      wait_drained(DRAIN_LIMIT);
      idle_cycles(4);

      if (out_due_q.size() == 0 && ret_due_q.size() == 0 && o_halted) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         stop_on_error("expected activity still pending at the end of the run");
      end
   end

endmodule

// File: compile.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/exec_stage.sv
logic/writeback_stage.sv
logic/cpu_top.sv
test/tb_cpu_top.sv

// File: Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - logic

sources:
  - logic/isa_pkg.sv
  - logic/pipe_pkg.sv
  - logic/inst_decoder.sv
  - logic/reg_file.sv
  - logic/alu.sv
  - logic/exec_stage.sv
  - logic/writeback_stage.sv
  - logic/cpu_top.sv
  - target: test
    files:
      - test/tb_cpu_top.sv
